//--- vector_mem_stimulus.txt
// cmd addr step count value vstep, all hex; item i uses addr+i*step and value+i*vstep
// cmd 1 host write, 2 host read, 3 buf write, 4 buf read, 5 start, 6 stall, 7 test end, 0 end
7 0 0 0 0 0
1 010 1 4 12340010 1
2 010 1 4 12340010 1
7 1 0 0 0 0
1 040 1 10 a5000040 1
5 040 1 10 0 0
4 0 1 10 a5000040 1
7 2 0 0 0 0
1 3f0 1 10 c00003f0 1
1 000 1 30 c0000000 1
3 0 1 10 5e000000 11
5 3fc 3 10 1 0
2 3fc 3 10 5e000000 11
2 3fb 3 2 c00003fb 3
2 3fd 1 1 c00003fd 0
2 000 3 f c0000000 3
2 001 3 e c0000001 3
7 3 0 0 0 0
5 040 1 0 1 0
2 040 1 10 a5000040 1
5 3fc 3 0 0 0
4 0 1 10 5e000000 11
7 4 0 0 0 0
6 0 0 0 0 0
5 040 1 10 0 0
4 0 1 10 a5000040 1
6 0 0 0 0 0
5 3fc 3 10 0 0
4 0 1 10 5e000000 11
7 5 0 0 0 0
0 0 0 0 0 0

//--- tb.f
+incdir+.
pkg_tpu.sv
agu.sv
local_memory.sv
vector_buffer.sv
lsu_control.sv
vector_mem_unit.sv
tb_vector_mem_unit.sv

//--- tb_vector_mem_unit.sv
/*
 * Testbench for the vector load/store unit
 * Replays command records from the stimulus file: host and buffer
 * accesses, load/store operations and random host stall windows
 */

`timescale 1ns/1ps
`default_nettype none

module tb_vector_mem_unit;

	localparam int rec_words    = 6;     // cmd addr step count value vstep
	localparam int max_recs     = 64;
	localparam int done_timeout = 200;   // Cycles allowed from start to done

	logic                   clock;
	logic                   reset;
	logic                   start;
	pkg_tpu::access_kind_t  kind;
	pkg_tpu::length_t       length;
	pkg_tpu::address_t      stride;
	pkg_tpu::address_t      base_addr;
	logic                   busy;
	logic                   done;
	logic                   host_en;
	logic                   host_we;
	pkg_tpu::address_t      host_addr;
	pkg_tpu::data_t         host_wdata;
	pkg_tpu::data_t         host_rdata;
	logic                   buf_wr_en;
	pkg_tpu::elem_index_t   buf_wr_index;
	pkg_tpu::data_t         buf_wr_data;
	pkg_tpu::elem_index_t   buf_rd_index;
	pkg_tpu::data_t         buf_rd_data;

	logic [31:0] stim [0:rec_words*max_recs-1];
	integer      seed;
	int          check_count;
	int          error_count;
	bit          timed_out;
	bit          stall_armed;    // Next operation gets random host reads

	vector_mem_unit vector_mem_unit_inst (
		.clock(clock), .reset(reset),
		.start(start), .kind(kind), .length(length),
		.stride(stride), .base_addr(base_addr),
		.busy(busy), .done(done),
		.host_en(host_en), .host_we(host_we), .host_addr(host_addr),
		.host_wdata(host_wdata), .host_rdata(host_rdata),
		.buf_wr_en(buf_wr_en), .buf_wr_index(buf_wr_index),
		.buf_wr_data(buf_wr_data),
		.buf_rd_index(buf_rd_index), .buf_rd_data(buf_rd_data)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;    // 8 ns period
	end

	////////////////////////////////////////
	// Checking and bus tasks

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		check_count++;
		assert (got === expected) else begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, expected);
			error_count++;
		end
	endtask

	function automatic string test_name(input int id);
		case (id)
			0:       return "reset state";
			1:       return "host port round trip";
			2:       return "unit-stride load";
			3:       return "strided store with wrap";
			4:       return "zero length";
			5:       return "load under host stalls";
			default: return "unnamed";
		endcase
	endfunction

	task automatic host_write(input pkg_tpu::address_t a, input pkg_tpu::data_t d);
		@(posedge clock);
		host_en    <= 1'b1;
		host_we    <= 1'b1;
		host_addr  <= a;
		host_wdata <= d;
		@(posedge clock);
		host_en <= 1'b0;
		host_we <= 1'b0;
	endtask

	// Read data shows up the cycle after the request
	task automatic host_read_check(input pkg_tpu::address_t a, input pkg_tpu::data_t expected);
		@(posedge clock);
		host_en   <= 1'b1;
		host_we   <= 1'b0;
		host_addr <= a;
		@(posedge clock);
		host_en <= 1'b0;
		@(negedge clock);
		check_value("host_rdata", host_rdata, expected);
	endtask

	task automatic buffer_write(input pkg_tpu::elem_index_t i, input pkg_tpu::data_t d);
		@(posedge clock);
		buf_wr_en    <= 1'b1;
		buf_wr_index <= i;
		buf_wr_data  <= d;
		@(posedge clock);
		buf_wr_en <= 1'b0;
	endtask

	task automatic buffer_read_check(input pkg_tpu::elem_index_t i,
			input pkg_tpu::data_t expected);
		@(posedge clock);
		buf_rd_index <= i;    // Combinational read
		@(negedge clock);
		check_value("buf_rd_data", buf_rd_data, expected);
	endtask

	// Start pulse in cycle 0, then follow the request schedule until done
	task automatic run_operation(input pkg_tpu::access_kind_t k, input pkg_tpu::length_t len,
			input pkg_tpu::address_t str, input pkg_tpu::address_t base,
			input bit with_stalls);
		int n;
		int pending;    // Requests still owed by the schedule
		int stalls;     // Host-active cycles that held a request back
		bit seen_done;
		n         = 0;
		pending   = len;
		stalls    = 0;
		seen_done = 1'b0;
		@(posedge clock);
		start     <= 1'b1;
		kind      <= k;
		length    <= len;
		stride    <= str;
		base_addr <= base;
		@(negedge clock);
		check_value("busy", busy, 1'b0);    // Still idle in cycle 0
		while (!seen_done && n < done_timeout) begin
			@(posedge clock);
			n++;
			start <= 1'b0;
			// Requests due from cycle 2, a host read pushes the rest back
			if (n >= 2 && pending > 0) begin
				if (with_stalls && ($random(seed) & 1)) begin
					host_en   <= 1'b1;
					host_we   <= 1'b0;
					host_addr <= '0;
					stalls++;
				end else begin
					host_en <= 1'b0;
					pending--;
				end
			end else begin
				host_en <= 1'b0;
			end
			@(negedge clock);
			check_value("busy", busy, 1'b1);
			seen_done = (done === 1'b1);
		end
		if (!seen_done) begin
			$display("Timeout: done did not arrive within %0d cycles of start", done_timeout);
			error_count++;
			timed_out = 1'b1;
		end else begin
			check_value("done latency", n, len + 3 + stalls);
			@(posedge clock);
			@(negedge clock);
			check_value("busy", busy, 1'b0);
			check_value("done", done, 1'b0);    // Single-cycle pulse
		end
	endtask

	////////////////////////////////////////
	// Command replay

	initial begin
		int          rec;
		int          i;
		int          test_checks;
		int          test_errors;
		bit          finished;
		logic [31:0] cmd;
		logic [31:0] addr;
		logic [31:0] step;
		logic [31:0] count;
		logic [31:0] value;
		logic [31:0] vstep;
		seed         = 32'h22c8;
		check_count  = 0;
		error_count  = 0;
		timed_out    = 1'b0;
		stall_armed  = 1'b0;
		reset        = 1'b1;
		start        = 1'b0;
		kind         = pkg_tpu::kind_load;
		length       = '0;
		stride       = '0;
		base_addr    = '0;
		host_en      = 1'b0;
		host_we      = 1'b0;
		host_addr    = '0;
		host_wdata   = '0;
		buf_wr_en    = 1'b0;
		buf_wr_index = '0;
		buf_wr_data  = '0;
		buf_rd_index = '0;
		$readmemh("vector_mem_stimulus.txt", stim);
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_value("busy", busy, 1'b0);
		check_value("done", done, 1'b0);
		rec         = 0;
		test_checks = 0;
		test_errors = 0;
		finished    = 1'b0;
		while (!finished && rec < max_recs) begin
			cmd   = stim[rec*rec_words];
			addr  = stim[rec*rec_words+1];
			step  = stim[rec*rec_words+2];
			count = stim[rec*rec_words+3];
			value = stim[rec*rec_words+4];
			vstep = stim[rec*rec_words+5];
			case (cmd)
				32'h1: for (i = 0; i < count; i++)
					host_write(pkg_tpu::address_t'(addr + i * step), value + i * vstep);
				32'h2: for (i = 0; i < count; i++)
					host_read_check(pkg_tpu::address_t'(addr + i * step), value + i * vstep);
				32'h3: for (i = 0; i < count; i++)
					buffer_write(pkg_tpu::elem_index_t'(addr + i * step), value + i * vstep);
				32'h4: for (i = 0; i < count; i++)
					buffer_read_check(pkg_tpu::elem_index_t'(addr + i * step),
						value + i * vstep);
				32'h5: begin
					run_operation(pkg_tpu::access_kind_t'(value[0]),
						pkg_tpu::length_t'(count), pkg_tpu::address_t'(step),
						pkg_tpu::address_t'(addr), stall_armed);
					stall_armed = 1'b0;
				end
				32'h6: stall_armed = 1'b1;
				32'h7: begin
					$display("Test %0d, %s: %0d checks, %0d errors", addr,
						test_name(int'(addr)), check_count - test_checks,
						error_count - test_errors);
					test_checks = check_count;
					test_errors = error_count;
				end
				32'h0: finished = 1'b1;
				default: begin
					$display("Stimulus record %0d has an unknown command %h", rec, cmd);
					error_count++;
					finished = 1'b1;
				end
			endcase
			if (timed_out) begin
				finished = 1'b1;
			end
			rec++;
		end
		$display("Total: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vector_mem_unit.sv
/*
 * Vector load/store unit top
 * Address generator, sequencer, local memory and vector buffer
 */

`timescale 1ns/1ps
`default_nettype none

module vector_mem_unit (
	input  wire                    clock,
	input  wire                    reset,
	// Operation request
	input  logic                   start,
	input  pkg_tpu::access_kind_t  kind,
	input  pkg_tpu::length_t       length,
	input  pkg_tpu::address_t      stride,
	input  pkg_tpu::address_t      base_addr,
	output logic                   busy,
	output logic                   done,
	// Host memory port
	input  logic                   host_en,
	input  logic                   host_we,
	input  pkg_tpu::address_t      host_addr,
	input  pkg_tpu::data_t         host_wdata,
	output pkg_tpu::data_t         host_rdata,
	// Buffer port, idle while busy
	input  logic                   buf_wr_en,
	input  pkg_tpu::elem_index_t   buf_wr_index,
	input  pkg_tpu::data_t         buf_wr_data,
	input  pkg_tpu::elem_index_t   buf_rd_index,
	output pkg_tpu::data_t         buf_rd_data
);

	logic                  agu_req;
	pkg_tpu::length_t      agu_length;
	pkg_tpu::address_t     agu_stride;
	pkg_tpu::address_t     agu_base;
	logic                  mem_req;
	pkg_tpu::address_t     mem_addr;
	logic                  end_access;
	logic                  vec_stall;
	logic                  mem_we;
	pkg_tpu::elem_index_t  elem_index;
	pkg_tpu::data_t        store_data;     // Buffer to memory
	pkg_tpu::data_t        vec_rdata;      // Memory to buffer
	logic                  load_wr_en;
	pkg_tpu::elem_index_t  load_wr_index;

	agu agu_inst (
		.clock(clock), .reset(reset),
		.req(agu_req), .stall(vec_stall),
		.length(agu_length), .stride(agu_stride), .base_addr(agu_base),
		.mem_req(mem_req), .mem_addr(mem_addr), .end_access(end_access)
	);

	lsu_control lsu_control_inst (
		.clock(clock), .reset(reset),
		.start(start), .kind(kind), .length(length),
		.stride(stride), .base_addr(base_addr),
		.agu_req(agu_req), .agu_length(agu_length),
		.agu_stride(agu_stride), .agu_base(agu_base),
		.mem_req(mem_req), .end_access(end_access),
		.mem_we(mem_we), .elem_index(elem_index),
		.load_wr_en(load_wr_en), .load_wr_index(load_wr_index),
		.busy(busy), .done(done)
	);

	local_memory local_memory_inst (
		.clock(clock), .reset(reset),
		.host_en(host_en), .host_we(host_we), .host_addr(host_addr),
		.host_wdata(host_wdata), .host_rdata(host_rdata),
		.vec_req(mem_req), .vec_we(mem_we), .vec_addr(mem_addr),
		.vec_wdata(store_data), .vec_rdata(vec_rdata), .vec_stall(vec_stall)
	);

	vector_buffer vector_buffer_inst (
		.clock(clock),
		.wr_en(load_wr_en), .wr_index(load_wr_index), .wr_data(vec_rdata),
		.rd_index(elem_index), .rd_data(store_data),
		.ext_wr_en(buf_wr_en), .ext_wr_index(buf_wr_index),
		.ext_wr_data(buf_wr_data),
		.ext_rd_index(buf_rd_index), .ext_rd_data(buf_rd_data)
	);

endmodule

`default_nettype wire

//--- lsu_control.sv
/*
 * Load/store sequencer
 * Latches an operation, kicks the address generator, steers store
 * data and load write-back, pulses done when the access drains
 */

`timescale 1ns/1ps
`default_nettype none

module lsu_control (
	input  wire                    clock,
	input  wire                    reset,
	input  logic                   start,          // One-cycle operation pulse
	input  pkg_tpu::access_kind_t  kind,
	input  pkg_tpu::length_t       length,
	input  pkg_tpu::address_t      stride,
	input  pkg_tpu::address_t      base_addr,
	output logic                   agu_req,
	output pkg_tpu::length_t       agu_length,
	output pkg_tpu::address_t      agu_stride,
	output pkg_tpu::address_t      agu_base,
	input  logic                   mem_req,        // Issued element request
	input  logic                   end_access,
	output logic                   mem_we,
	output pkg_tpu::elem_index_t   elem_index,     // Element of current request
	output logic                   load_wr_en,     // Write-back of loaded word
	output pkg_tpu::elem_index_t   load_wr_index,
	output logic                   busy,
	output logic                   done
);

	pkg_tpu::lsu_state_t    state;
	pkg_tpu::access_kind_t  op_kind;
	logic                   accept;
	logic                   is_load;

	assign accept  = start && (state == pkg_tpu::lsu_idle);
	assign is_load = (op_kind == pkg_tpu::kind_load);

	////////////////////////////////////////
	// FSM

	always_ff @(posedge clock) begin
		if (reset) begin
			state   <= pkg_tpu::lsu_idle;
			agu_req <= 1'b0;
		end else begin
			agu_req <= accept;    // Generator loads one cycle later
			case (state)
				pkg_tpu::lsu_idle:   if (start) state <= pkg_tpu::lsu_run;
				pkg_tpu::lsu_run:    if (end_access) state <= pkg_tpu::lsu_finish;
				pkg_tpu::lsu_finish: state <= pkg_tpu::lsu_idle;
				default:             state <= pkg_tpu::lsu_idle;
			endcase
		end
	end

	assign busy = (state != pkg_tpu::lsu_idle);
	assign done = (state == pkg_tpu::lsu_finish);

	// Operation latch
	always_ff @(posedge clock) begin
		if (accept) begin
			op_kind    <= kind;
			agu_length <= length;
			agu_stride <= stride;
			agu_base   <= base_addr;
		end
	end

	////////////////////////////////////////
	// Element tracking and data steering

	always_ff @(posedge clock) begin
		if (reset || accept) begin
			elem_index <= '0;
		end else if (mem_req) begin
			elem_index <= elem_index + 1'b1;
		end
	end

	assign mem_we = mem_req && !is_load;    // Store writes same cycle

	// Load data returns a cycle after the request
	always_ff @(posedge clock) begin
		if (reset) begin
			load_wr_en <= 1'b0;
		end else begin
			load_wr_en <= mem_req && is_load;
		end
	end

	always_ff @(posedge clock) begin
		load_wr_index <= elem_index;
	end

	assert property (@(posedge clock) disable iff (reset) start |-> !busy)
		else $error("lsu_control: start while busy");

	assert property (@(posedge clock) disable iff (reset) done |=> !done)
		else $error("lsu_control: done longer than one cycle");

endmodule

`default_nettype wire

//--- vector_buffer.sv
/*
 * Vector staging buffer
 * 16 words between local memory and the outside, two write ports
 * with the internal one winning, two combinational read ports
 */

`timescale 1ns/1ps
`default_nettype none

`include "tpu_settings.svh"

module vector_buffer (
	input  wire                   clock,
	input  logic                  wr_en,         // Load write-back
	input  pkg_tpu::elem_index_t  wr_index,
	input  pkg_tpu::data_t        wr_data,
	input  pkg_tpu::elem_index_t  rd_index,      // Store data source
	output pkg_tpu::data_t        rd_data,
	input  logic                  ext_wr_en,     // Outside preload
	input  pkg_tpu::elem_index_t  ext_wr_index,
	input  pkg_tpu::data_t        ext_wr_data,
	input  pkg_tpu::elem_index_t  ext_rd_index,  // Outside readback
	output pkg_tpu::data_t        ext_rd_data
);

	pkg_tpu::data_t elems [0:`TPU_VLEN-1];

	// Internal write last so it wins on the same slot
	always_ff @(posedge clock) begin
		if (ext_wr_en) begin
			elems[ext_wr_index] <= ext_wr_data;
		end
		if (wr_en) begin
			elems[wr_index] <= wr_data;
		end
	end

	assign rd_data     = elems[rd_index];
	assign ext_rd_data = elems[ext_rd_index];

endmodule

`default_nettype wire

//--- local_memory.sv
/*
 * Local word memory
 * Single port, registered read; host access wins over the vector
 * port and stalls it for that cycle
 */

`timescale 1ns/1ps
`default_nettype none

module local_memory (
	input  wire                clock,
	input  wire                reset,
	input  logic               host_en,
	input  logic               host_we,
	input  pkg_tpu::address_t  host_addr,
	input  pkg_tpu::data_t     host_wdata,
	output pkg_tpu::data_t     host_rdata,   // Valid one cycle after host read
	input  logic               vec_req,
	input  logic               vec_we,
	input  pkg_tpu::address_t  vec_addr,
	input  pkg_tpu::data_t     vec_wdata,
	output pkg_tpu::data_t     vec_rdata,    // Valid one cycle after vector read
	output logic               vec_stall
);

	localparam int unsigned depth = 2 ** $bits(pkg_tpu::address_t);

	pkg_tpu::data_t     mem [0:depth-1];
	pkg_tpu::data_t     rd_data;      // Shared read register
	logic               port_en;
	logic               port_we;
	pkg_tpu::address_t  port_addr;
	pkg_tpu::data_t     port_wdata;

	////////////////////////////////////////
	// Port arbitration, host first

	assign vec_stall  = host_en;
	assign port_en    = host_en || vec_req;
	assign port_we    = host_en ? host_we    : vec_we;
	assign port_addr  = host_en ? host_addr  : vec_addr;
	assign port_wdata = host_en ? host_wdata : vec_wdata;

	always_ff @(posedge clock) begin
		if (port_en && port_we) begin
			mem[port_addr] <= port_wdata;
		end
	end

	// Read register for both ports
	always_ff @(posedge clock) begin
		if (reset) begin
			rd_data <= '0;
		end else if (port_en && !port_we) begin
			rd_data <= mem[port_addr];
		end
	end

	assign host_rdata = rd_data;
	assign vec_rdata  = rd_data;

	// Generator must honour the stall
	assert property (@(posedge clock) disable iff (reset) host_en |-> !vec_req)
		else $error("local_memory: vector request while host active");

endmodule

`default_nettype wire

//--- agu.sv
/*
 * Strided address generator
 * Issues one memory request per element from base by stride,
 * holds off while the memory stalls, flags the end of the access
 */

`timescale 1ns/1ps
`default_nettype none

module agu (
	input  wire                clock,
	input  wire                reset,
	input  logic               req,         // Load config and start walking
	input  logic               stall,       // Memory busy with host this cycle
	input  pkg_tpu::length_t   length,
	input  pkg_tpu::address_t  stride,
	input  pkg_tpu::address_t  base_addr,
	output logic               mem_req,     // Element request issued
	output pkg_tpu::address_t  mem_addr,
	output logic               end_access   // All elements issued
);

	logic               run;          // Access in progress
	pkg_tpu::length_t   remaining;    // Elements still to issue
	pkg_tpu::address_t  step;         // Latched stride
	pkg_tpu::address_t  addr;         // Next element address
	logic               load_config;

	assign load_config = req && !run;

	// Request only when elements remain and memory is free
	assign mem_req    = run && (remaining != '0) && !stall;
	assign end_access = run && (remaining == '0);
	assign mem_addr   = addr;

	////////////////////////////////////////
	// Control

	always_ff @(posedge clock) begin
		if (reset) begin
			run <= 1'b0;
		end else if (end_access) begin
			run <= 1'b0;    // Back to idle after the last element
		end else if (load_config) begin
			run <= 1'b1;
		end
	end

	// Counts down only on issued requests
	always_ff @(posedge clock) begin
		if (reset) begin
			remaining <= '0;
		end else if (load_config) begin
			remaining <= length;
		end else if (mem_req) begin
			remaining <= remaining - 1'b1;
		end
	end

	////////////////////////////////////////
	// Address path

	always_ff @(posedge clock) begin
		if (load_config) begin
			step <= stride;
			addr <= base_addr;
		end else if (mem_req) begin
			addr <= addr + step;    // Wraps modulo memory size
		end
	end

	// Stall must not skip an address
	assert property (@(posedge clock) disable iff (reset)
		run && stall |=> $stable(mem_addr))
		else $error("agu: address moved during stall");

endmodule

`default_nettype wire

//--- pkg_tpu.sv
/*
 * Tensor tile vector load/store path
 * Shared types for the address generator, sequencer, memory and buffer
 */

`default_nettype none

`include "tpu_settings.svh"

package pkg_tpu;

	typedef logic [`TPU_ADDR_WIDTH-1:0]       address_t;    // Word address, stride too
	typedef logic [`TPU_DATA_WIDTH-1:0]       data_t;       // One memory word
	typedef logic [$clog2(`TPU_VLEN):0]       length_t;     // Element count 0..16
	typedef logic [$clog2(`TPU_VLEN)-1:0]     elem_index_t; // Buffer slot

	// Direction of a vector access
	typedef enum logic {
		kind_load  = 1'b0,
		kind_store = 1'b1
	} access_kind_t;

	// Sequencer FSM states
	typedef enum logic [1:0] {
		lsu_idle   = 2'd0,
		lsu_run    = 2'd1,
		lsu_finish = 2'd2
	} lsu_state_t;

endpackage

`default_nettype wire

//--- tpu_settings.svh
/*
 * Tensor tile vector load/store path
 * Global widths and sizes shared by the package and the RTL
 */

`ifndef TPU_SETTINGS_SVH
`define TPU_SETTINGS_SVH

// Word address into local memory, 1024 words
`define TPU_ADDR_WIDTH 10

// Memory and vector element word
`define TPU_DATA_WIDTH 32

// Max elements per vector access
`define TPU_VLEN 16

`endif
